/* design/rsPkg.sv */
`default_nettype none

package rsPkg;

    localparam int DataWidth   = 32;
    localparam int RobTagWidth = 4;
    localparam int RobEntries  = 16;   // One valid bit and value per ROB tag

    // Instructions handled by this station
    typedef enum logic [4:0] {
        OpAdd,
        OpSub,
        OpAnd,
        OpOr,
        OpXor,
        OpSll,
        OpSrl,
        OpSra,
        OpSlt,
        OpSltu,
        OpAddi,
        OpAndi,
        OpOri,
        OpXori,
        OpSlli,
        OpSrli,
        OpSrai,
        OpSlti,
        OpSltiu,
        OpLui,
        OpAuipc,
        OpJal,
        OpJalr,
        OpBeq,
        OpBne,
        OpBlt,
        OpBge,
        OpBltu,
        OpBgeu
    } rsOp_e;

    // Lt and Ge are signed, Ltu and Geu unsigned
    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSll,
        AluSrl,
        AluSra,
        AluLt,
        AluLtu,
        AluEq,
        AluNe,
        AluGe,
        AluGeu
    } aluOp_e;

    typedef struct packed {
        logic                   pending;   // Still waiting on tag
        logic [RobTagWidth-1:0] tag;
        logic [DataWidth-1:0]   value;
    } rsSrc_t;

    // srcJ holds the pc for AUIPC and JAL, srcK the link for jumps
    // imm[0] is the taken prediction for branches
    typedef struct packed {
        rsOp_e                  op;
        rsSrc_t                 srcJ;
        rsSrc_t                 srcK;
        logic [DataWidth-1:0]   imm;
        logic [RobTagWidth-1:0] robTag;
    } rsDispatch_t;

    typedef struct packed {
        logic        busy;
        logic        issued;
        rsDispatch_t inst;
    } rsEntry_t;

    typedef struct packed {
        aluOp_e               op;
        logic [DataWidth-1:0] lhs;
        logic [DataWidth-1:0] rhs;
    } aluReq_t;

    typedef struct packed {
        logic [RobTagWidth-1:0] tag;
        logic [DataWidth-1:0]   value;
        logic [DataWidth-1:0]   target;   // Jump destination, else zero
    } robWrite_t;

endpackage

`default_nettype wire

/* design/slotPicker.sv */
`timescale 1ns/1ps
`default_nettype none

module slotPicker #(
    parameter int Entries = 8
) (
    input  logic [Entries-1:0]                                request,
    output logic                                              found,
    output logic [((Entries > 1) ? $clog2(Entries) : 1)-1:0] index
);

    localparam int IdxWidth = (Entries > 1) ? $clog2(Entries) : 1;

    // Scan from the top so the lowest set bit wins
    always_comb begin
        found = 1'b0;
        index = '0;
        for (int i = Entries - 1; i >= 0; i--) begin
            if (request[i]) begin
                found = 1'b1;
                index = IdxWidth'(i);
            end
        end
    end

endmodule

`default_nettype wire

/* design/rsEntryTable.sv */
`timescale 1ns/1ps
`default_nettype none

module rsEntryTable #(
    parameter int Entries = 8
) (
    input  logic                                                       clk,
    input  logic                                                       rst,
    input  logic                                                       clr,
    input  logic                                                       dispatch,
    input  rsPkg::rsDispatch_t                                         dispatchData,
    input  logic [((Entries > 1) ? $clog2(Entries) : 1)-1:0]           writeIdx,
    input  logic [rsPkg::RobEntries-1:0]                               robValid,
    input  logic [rsPkg::RobEntries-1:0][rsPkg::DataWidth-1:0]         robValue,
    input  logic                                                       issue,
    input  logic [((Entries > 1) ? $clog2(Entries) : 1)-1:0]           issueIdx,
    input  logic                                                       releaseEn,
    input  logic [((Entries > 1) ? $clog2(Entries) : 1)-1:0]           releaseIdx,
    output logic [Entries-1:0]                                         busy,
    output logic [Entries-1:0]                                         ready,
    output rsPkg::rsEntry_t [Entries-1:0]                              entries
);

    localparam int IdxWidth = (Entries > 1) ? $clog2(Entries) : 1;

    logic [Entries-1:0]       busyQ;
    logic [Entries-1:0]       issuedQ;
    rsPkg::rsDispatch_t       slot [Entries];
    logic                     accept;

    // Picker hands over the lowest free slot, busy here means full
    assign accept = dispatch && !clr && !busyQ[writeIdx];

    // Grab the ROB value if the tag has been produced
    function automatic rsPkg::rsSrc_t wake(input rsPkg::rsSrc_t src);
        rsPkg::rsSrc_t res;
        res = src;
        if (src.pending && robValid[src.tag]) begin
            res.pending = 1'b0;
            res.value   = robValue[src.tag];
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            busyQ   <= '0;
            issuedQ <= '0;
        end else begin
            if (issue) begin
                issuedQ[issueIdx] <= 1'b1;
            end
            if (accept) begin
                busyQ[writeIdx]   <= 1'b1;
                issuedQ[writeIdx] <= 1'b0;
            end
            if (releaseEn) begin
                busyQ[releaseIdx]   <= 1'b0;
                issuedQ[releaseIdx] <= 1'b0;
            end
        end
    end

    // Operand capture, at insert and on every later edge
    always_ff @(posedge clk) begin
        for (int i = 0; i < Entries; i++) begin
            if (accept && writeIdx == IdxWidth'(i)) begin
                slot[i]      <= dispatchData;
                slot[i].srcJ <= wake(dispatchData.srcJ);
                slot[i].srcK <= wake(dispatchData.srcK);
            end else begin
                slot[i].srcJ <= wake(slot[i].srcJ);
                slot[i].srcK <= wake(slot[i].srcK);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < Entries; i++) begin
            entries[i].busy   = busyQ[i];
            entries[i].issued = issuedQ[i];
            entries[i].inst   = slot[i];
            ready[i] = busyQ[i] && !issuedQ[i]
                       && !slot[i].srcJ.pending && !slot[i].srcK.pending;
        end
    end

    assign busy = busyQ;

endmodule

`default_nettype wire

/* design/issueStage.sv */
`timescale 1ns/1ps
`default_nettype none

module issueStage #(
    parameter int Entries = 8
) (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             clr,
    input  logic                                             hasReady,
    input  logic [((Entries > 1) ? $clog2(Entries) : 1)-1:0] readyIdx,
    input  rsPkg::rsEntry_t [Entries-1:0]                    entries,
    input  logic                                             aluBusy,
    output logic                                             issue,
    output logic [((Entries > 1) ? $clog2(Entries) : 1)-1:0] issueIdx,
    output logic                                             aluReqValid,
    output rsPkg::aluReq_t                                   aluReq
);

    rsPkg::rsDispatch_t sel;
    rsPkg::aluReq_t     req;

    assign sel      = entries[readyIdx].inst;
    assign issue    = hasReady && !aluBusy && !clr;   // One ALU op in flight
    assign issueIdx = readyIdx;

    always_comb begin
        req.lhs = sel.srcJ.value;
        req.rhs = sel.srcK.value;

        case (sel.op)
            rsPkg::OpSub:                    req.op = rsPkg::AluSub;
            rsPkg::OpAnd, rsPkg::OpAndi:     req.op = rsPkg::AluAnd;
            rsPkg::OpOr, rsPkg::OpOri:       req.op = rsPkg::AluOr;
            rsPkg::OpXor, rsPkg::OpXori:     req.op = rsPkg::AluXor;
            rsPkg::OpSll, rsPkg::OpSlli:     req.op = rsPkg::AluSll;
            rsPkg::OpSrl, rsPkg::OpSrli:     req.op = rsPkg::AluSrl;
            rsPkg::OpSra, rsPkg::OpSrai:     req.op = rsPkg::AluSra;
            rsPkg::OpSlt, rsPkg::OpSlti:     req.op = rsPkg::AluLt;
            rsPkg::OpSltu, rsPkg::OpSltiu:   req.op = rsPkg::AluLtu;
            rsPkg::OpBeq:                    req.op = rsPkg::AluEq;
            rsPkg::OpBne:                    req.op = rsPkg::AluNe;
            rsPkg::OpBlt:                    req.op = rsPkg::AluLt;
            rsPkg::OpBge:                    req.op = rsPkg::AluGe;
            rsPkg::OpBltu:                   req.op = rsPkg::AluLtu;
            rsPkg::OpBgeu:                   req.op = rsPkg::AluGeu;
            default:                         req.op = rsPkg::AluAdd;   // Add, LUI, AUIPC, jumps
        endcase

        // Right operand from the immediate where the form asks for it
        case (sel.op)
            rsPkg::OpAddi, rsPkg::OpAndi, rsPkg::OpOri, rsPkg::OpXori,
            rsPkg::OpSlli, rsPkg::OpSrli, rsPkg::OpSrai,
            rsPkg::OpSlti, rsPkg::OpSltiu, rsPkg::OpJalr: begin
                req.rhs = sel.imm;
            end
            rsPkg::OpLui: begin
                req.lhs = '0;
                req.rhs = sel.imm;
            end
            rsPkg::OpAuipc: req.rhs = {sel.imm[31:12], 12'b0};   // pc in srcJ
            rsPkg::OpJal:   req.rhs = {sel.imm[31:1], 1'b0};
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            aluReqValid <= 1'b0;
        end else begin
            aluReqValid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            aluReq <= req;
        end
    end

endmodule

`default_nettype wire

/* design/completeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module completeStage #(
    parameter int Entries = 8
) (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             clr,
    input  logic                                             issue,
    input  logic [((Entries > 1) ? $clog2(Entries) : 1)-1:0] issueIdx,
    input  rsPkg::rsEntry_t [Entries-1:0]                    entries,
    input  logic                                             aluDone,
    input  logic [rsPkg::DataWidth-1:0]                      aluResult,
    output logic                                             aluBusy,
    output logic                                             releaseEn,
    output logic [((Entries > 1) ? $clog2(Entries) : 1)-1:0] releaseIdx,
    output logic                                             robWriteValid,
    output rsPkg::robWrite_t                                 robWriteData,
    output logic                                             trainValid,
    output logic                                             trainMispredict
);

    logic                  pendingQ;
    logic [$bits(issueIdx)-1:0] idxQ;
    rsPkg::rsDispatch_t    cur;
    rsPkg::robWrite_t      wr;
    logic                  isBranch;

    assign cur        = entries[idxQ].inst;
    assign releaseEn  = aluDone && pendingQ;
    assign releaseIdx = idxQ;
    assign aluBusy    = pendingQ && !aluDone;   // Lets the next op go in the done cycle

    always_comb begin
        isBranch  = 1'b0;
        wr.tag    = cur.robTag;
        wr.value  = aluResult;
        wr.target = '0;
        case (cur.op)
            rsPkg::OpBeq, rsPkg::OpBne, rsPkg::OpBlt,
            rsPkg::OpBge, rsPkg::OpBltu, rsPkg::OpBgeu: begin
                isBranch = 1'b1;
                wr.value = {cur.imm[31:1], aluResult[0]};   // Outcome in bit 0
            end
            rsPkg::OpJal, rsPkg::OpJalr: begin
                wr.value  = cur.srcK.value;
                wr.target = aluResult;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            pendingQ      <= 1'b0;
            robWriteValid <= 1'b0;
            trainValid    <= 1'b0;
        end else begin
            robWriteValid <= releaseEn;
            trainValid    <= releaseEn && isBranch;
            if (issue) begin
                pendingQ <= 1'b1;
            end else if (releaseEn) begin
                pendingQ <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            idxQ <= issueIdx;
        end
        if (releaseEn) begin
            robWriteData    <= wr;
            trainMispredict <= cur.imm[0] ^ aluResult[0];
        end
    end

endmodule

`default_nettype wire

/* design/reservationStation.sv */
`timescale 1ns/1ps
`default_nettype none

module reservationStation #(
    parameter int Entries = 8
) (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               clr,
    input  logic                                               dispatch,
    input  rsPkg::rsDispatch_t                                 dispatchData,
    output logic                                               full,
    input  logic [rsPkg::RobEntries-1:0]                       robValid,
    input  logic [rsPkg::RobEntries-1:0][rsPkg::DataWidth-1:0] robValue,
    output logic                                               aluReqValid,
    output rsPkg::aluReq_t                                     aluReq,
    input  logic                                               aluDone,
    input  logic [rsPkg::DataWidth-1:0]                        aluResult,
    output logic                                               robWriteValid,
    output rsPkg::robWrite_t                                   robWriteData,
    output logic                                               trainValid,
    output logic                                               trainMispredict
);

    localparam int IdxWidth = (Entries > 1) ? $clog2(Entries) : 1;

    logic [Entries-1:0]            busy;
    logic [Entries-1:0]            ready;
    rsPkg::rsEntry_t [Entries-1:0] entries;
    logic                          hasFree;
    logic                          hasReady;
    logic [IdxWidth-1:0]           freeIdx;
    logic [IdxWidth-1:0]           readyIdx;
    logic                          issue;
    logic [IdxWidth-1:0]           issueIdx;
    logic                          aluBusy;
    logic                          releaseEn;
    logic [IdxWidth-1:0]           releaseIdx;

    assign full = !hasFree;

    rsEntryTable #(.Entries(Entries)) table0 (
        .clk(clk), .rst(rst), .clr(clr),
        .dispatch(dispatch), .dispatchData(dispatchData), .writeIdx(freeIdx),
        .robValid(robValid), .robValue(robValue),
        .issue(issue), .issueIdx(issueIdx),
        .releaseEn(releaseEn), .releaseIdx(releaseIdx),
        .busy(busy), .ready(ready), .entries(entries)
    );

    slotPicker #(.Entries(Entries)) freePick (
        .request(~busy), .found(hasFree), .index(freeIdx)
    );

    slotPicker #(.Entries(Entries)) readyPick (
        .request(ready), .found(hasReady), .index(readyIdx)
    );

    issueStage #(.Entries(Entries)) issue0 (
        .clk(clk), .rst(rst), .clr(clr),
        .hasReady(hasReady), .readyIdx(readyIdx), .entries(entries), .aluBusy(aluBusy),
        .issue(issue), .issueIdx(issueIdx),
        .aluReqValid(aluReqValid), .aluReq(aluReq)
    );

    completeStage #(.Entries(Entries)) complete0 (
        .clk(clk), .rst(rst), .clr(clr),
        .issue(issue), .issueIdx(issueIdx), .entries(entries),
        .aluDone(aluDone), .aluResult(aluResult), .aluBusy(aluBusy),
        .releaseEn(releaseEn), .releaseIdx(releaseIdx),
        .robWriteValid(robWriteValid), .robWriteData(robWriteData),
        .trainValid(trainValid), .trainMispredict(trainMispredict)
    );

endmodule

`default_nettype wire

/* verification/reservationStation_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module reservationStation_properties (
    input logic clk,
    input logic rst,
    input logic clr,
    input logic aluReqValid,
    input logic aluDone,
    input logic robWriteValid,
    input logic trainValid
);

    int   failCount = 0;
    logic inFlight;   // ALU request sent, no done yet

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            inFlight <= 1'b0;
        end else if (aluReqValid) begin
            inFlight <= 1'b1;
        end else if (aluDone) begin
            inFlight <= 1'b0;
        end
    end

    singleRequest: assert property (@(posedge clk) disable iff (rst)
        aluReqValid |-> !inFlight)
        else begin
            failCount++;
            $error("ALU request sent while another one is outstanding");
        end

    writeAfterDone: assert property (@(posedge clk) disable iff (rst || clr)
        aluDone |=> robWriteValid)
        else begin
            failCount++;
            $error("no ROB write in the cycle after ALU done");
        end

    writeOnlyAfterDone: assert property (@(posedge clk) disable iff (rst)
        robWriteValid |-> $past(aluDone))
        else begin
            failCount++;
            $error("ROB write without ALU done one cycle before");
        end

    trainWithWrite: assert property (@(posedge clk) disable iff (rst)
        trainValid |-> robWriteValid)
        else begin
            failCount++;
            $error("predictor training without a ROB write");
        end

    // Strobes stay low right after reset or flush
    quietAfterClear: assert property (@(posedge clk)
        (rst || clr) |=> !(aluReqValid || robWriteValid || trainValid))
        else begin
            failCount++;
            $error("output strobe high in the cycle after reset or flush");
        end

endmodule

bind reservationStation reservationStation_properties props (.*);

`default_nettype wire

/* verification/reservationStationTb.sv */
`timescale 1ns/1ps
`default_nettype none

module reservationStationTb;

    localparam int Entries     = 8;
    localparam int ClkPeriod   = 100;
    localparam int NumOps      = 29;   // Every kept instruction
    localparam int NumWake     = 16;
    localparam int NumDispatch = NumOps + NumWake + Entries + 4;

    logic                                               clk;
    logic                                               rst;
    logic                                               clr;
    logic                                               dispatch;
    rsPkg::rsDispatch_t                                 dispatchData;
    logic                                               full;
    logic [rsPkg::RobEntries-1:0]                       robValid;
    logic [rsPkg::RobEntries-1:0][rsPkg::DataWidth-1:0] robValue;
    logic                                               aluReqValid;
    rsPkg::aluReq_t                                     aluReq;
    logic                                               aluDone;
    logic [rsPkg::DataWidth-1:0]                        aluResult;
    logic                                               robWriteValid;
    rsPkg::robWrite_t                                   robWriteData;
    logic                                               trainValid;
    logic                                               trainMispredict;

    logic [15:0]        lfsr   = 16'd63;
    int                 checks = 0;
    int                 errors = 0;
    rsPkg::rsDispatch_t sent [$];   // Dispatched instructions with woken values

    reservationStation #(.Entries(Entries)) UUT (.*);

    always #(ClkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] rnd(input int bits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < bits; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Reference decode of one dispatched instruction
    function automatic rsPkg::aluReq_t expectReq(input rsPkg::rsDispatch_t d);
        rsPkg::aluReq_t r;
        rsPkg::rsOp_e   base;
        base  = d.op;
        r.lhs = d.srcJ.value;
        r.rhs = d.srcK.value;
        if (d.op inside {[rsPkg::OpAddi:rsPkg::OpSltiu]}) begin
            r.rhs = d.imm;
            base  = (d.op == rsPkg::OpAddi) ? rsPkg::OpAdd : rsPkg::rsOp_e'(d.op - 5'd9);
        end
        if (base <= rsPkg::OpSltu) begin
            r.op = rsPkg::aluOp_e'(base);   // Register ops share the ALU order
        end else begin
            case (base)
                rsPkg::OpBeq:  r.op = rsPkg::AluEq;
                rsPkg::OpBne:  r.op = rsPkg::AluNe;
                rsPkg::OpBlt:  r.op = rsPkg::AluLt;
                rsPkg::OpBge:  r.op = rsPkg::AluGe;
                rsPkg::OpBltu: r.op = rsPkg::AluLtu;
                rsPkg::OpBgeu: r.op = rsPkg::AluGeu;
                default:       r.op = rsPkg::AluAdd;
            endcase
        end
        case (d.op)
            rsPkg::OpLui: begin
                r.lhs = '0;
                r.rhs = d.imm;
            end
            rsPkg::OpAuipc: r.rhs = {d.imm[31:12], 12'h0};
            rsPkg::OpJal:   r.rhs = {d.imm[31:1], 1'b0};
            rsPkg::OpJalr:  r.rhs = d.imm;
            default: ;
        endcase
        return r;
    endfunction

    // External ALU model
    function automatic logic [31:0] aluCalc(input rsPkg::aluReq_t r);
        case (r.op)
            rsPkg::AluSub: return r.lhs - r.rhs;
            rsPkg::AluAnd: return r.lhs & r.rhs;
            rsPkg::AluOr:  return r.lhs | r.rhs;
            rsPkg::AluXor: return r.lhs ^ r.rhs;
            rsPkg::AluSll: return r.lhs << r.rhs[4:0];
            rsPkg::AluSrl: return r.lhs >> r.rhs[4:0];
            rsPkg::AluSra: return $signed(r.lhs) >>> r.rhs[4:0];
            rsPkg::AluLt:  return 32'($signed(r.lhs) < $signed(r.rhs));
            rsPkg::AluLtu: return 32'(r.lhs < r.rhs);
            rsPkg::AluEq:  return 32'(r.lhs == r.rhs);
            rsPkg::AluNe:  return 32'(r.lhs != r.rhs);
            rsPkg::AluGe:  return 32'($signed(r.lhs) >= $signed(r.rhs));
            rsPkg::AluGeu: return 32'(r.lhs >= r.rhs);
            default:       return r.lhs + r.rhs;
        endcase
    endfunction

    function automatic rsPkg::rsDispatch_t randomInst(input rsPkg::rsOp_e op);
        rsPkg::rsDispatch_t d;
        d            = '0;
        d.op         = op;
        d.srcJ.tag   = 4'(rnd(4));
        d.srcJ.value = rnd(32);
        d.srcK.tag   = 4'(rnd(4));
        d.srcK.value = rnd(1) ? d.srcJ.value : rnd(32);   // Equal operands now and then
        d.imm        = rnd(32);
        d.robTag     = 4'(rnd(4));
        return d;
    endfunction

    task automatic expectEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Oldest dispatched instruction through the ALU and back to the ROB
    task automatic serveOne();
        rsPkg::rsDispatch_t d;
        rsPkg::rsOp_e       op;
        rsPkg::aluReq_t     exp;
        logic [31:0]        res;
        logic               isBranch;
        logic               isJump;
        d  = sent.pop_front();
        op = d.op;
        for (int n = 0; n < 20 && !aluReqValid; n++) begin
            step();
        end
        if (!aluReqValid) begin
            errors++;
            $display("no ALU request arrived by %0t for %s", $time, op.name());
            return;
        end
        exp = expectReq(d);
        expectEq(aluReq.op, exp.op, "ALU op");
        expectEq(aluReq.lhs, exp.lhs, "ALU lhs");
        expectEq(aluReq.rhs, exp.rhs, "ALU rhs");
        res = aluCalc(aluReq);
        repeat (1 + rnd(2)) step();   // Latency 1 to 4
        aluDone   = 1'b1;
        aluResult = res;
        step();
        aluDone  = 1'b0;
        isBranch = op inside {[rsPkg::OpBeq:rsPkg::OpBgeu]};
        isJump   = op inside {rsPkg::OpJal, rsPkg::OpJalr};
        expectEq(robWriteValid, 1'b1, "ROB write strobe");
        expectEq(robWriteData.tag, d.robTag, "ROB tag");
        expectEq(robWriteData.value,
                 isJump ? d.srcK.value : (isBranch ? {d.imm[31:1], res[0]} : res),
                 "ROB value");
        expectEq(robWriteData.target, isJump ? res : 32'h0, "ROB target");
        expectEq(trainValid, isBranch, "train strobe");
        if (isBranch) begin
            expectEq(trainMispredict, d.imm[0] ^ res[0], "mispredict bit");
        end
    endtask

    // wakeMode 0 all present, 1 srcJ valid at insert, 2 srcK woken later
    task automatic runOne(input rsPkg::rsOp_e op, input int wakeMode);
        rsPkg::rsDispatch_t d;
        logic [31:0]        late;
        d        = randomInst(op);
        late     = rnd(32);
        robValid = '0;
        if (wakeMode == 1) begin
            d.srcJ.pending       = 1'b1;
            robValid[d.srcJ.tag] = 1'b1;
            robValue[d.srcJ.tag] = late;
        end else if (wakeMode == 2) begin
            d.srcK.pending = 1'b1;
        end
        dispatchData = d;
        dispatch     = 1'b1;
        step();
        dispatch = 1'b0;
        if (wakeMode == 2) begin
            repeat (3) begin
                step();
                expectEq(aluReqValid, 1'b0, "request while source pending");
            end
            robValid[d.srcK.tag] = 1'b1;
            robValue[d.srcK.tag] = late;
            d.srcK.value         = late;
        end else if (wakeMode == 1) begin
            robValid     = '0;   // Tag valid at the insert edge only
            d.srcJ.value = late;
        end
        sent.push_back(d);
        serveOne();
    endtask

    // Second ready entry waits for the first one's ALU done
    task automatic runPair(input rsPkg::rsOp_e opA, input rsPkg::rsOp_e opB);
        robValid     = '0;
        dispatchData = randomInst(opA);
        sent.push_back(dispatchData);
        dispatch     = 1'b1;
        step();
        dispatchData = randomInst(opB);
        sent.push_back(dispatchData);
        step();
        dispatch = 1'b0;
        serveOne();
        serveOne();
    endtask

    task automatic fillAndFlush();
        rsPkg::rsDispatch_t d;
        robValid = '0;
        for (int i = 0; i <= Entries; i++) begin
            d              = '0;
            d.op           = rsPkg::OpAdd;
            d.srcJ.pending = (i < Entries);   // Last one would be ready at once
            d.srcJ.tag     = 4'(i);
            d.srcJ.value   = 32'hD00D_0000 + i;
            d.robTag       = 4'(i);
            dispatchData   = d;
            dispatch       = 1'b1;
            expectEq(full, i == Entries, "full flag");
            step();
        end
        dispatch = 1'b0;
        repeat (4) begin
            step();
            expectEq(aluReqValid, 1'b0, "request from dropped dispatch");
        end
        clr = 1'b1;
        step();
        clr      = 1'b0;
        robValid = '1;   // Would wake any entry left behind
        expectEq(full, 1'b0, "full after flush");
        repeat (4) begin
            step();
            expectEq(aluReqValid, 1'b0, "request after flush");
        end
    endtask

    initial begin
        #((NumDispatch * 20 + 100) * ClkPeriod);
        $display("watchdog expired before the tests finished");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        clr          = 1'b0;
        dispatch     = 1'b0;
        dispatchData = '0;
        robValid     = '0;
        robValue     = '0;
        aluDone      = 1'b0;
        aluResult    = '0;
        repeat (2) step();
        rst = 1'b0;
        for (int k = 0; k < NumOps; k++) begin
            runOne(rsPkg::rsOp_e'(k), 0);
        end
        for (int k = 0; k < NumWake; k++) begin
            runOne(rsPkg::rsOp_e'(rnd(5) % NumOps), 1 + k % 2);
        end
        runPair(rsPkg::OpBne, rsPkg::OpJalr);
        fillAndFlush();
        runOne(rsPkg::OpSub, 2);
        repeat (2) step();
        $display("checks %0d, testbench errors %0d, assertion failures %0d",
                 checks, errors, UUT.props.failCount);
        if (errors == 0 && UUT.props.failCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
design/rsPkg.sv
design/slotPicker.sv
design/rsEntryTable.sv
design/issueStage.sv
design/completeStage.sv
design/reservationStation.sv
verification/reservationStation_properties.sv
verification/reservationStationTb.sv

/* Bender.yml */
package:
  name: reservation_station

sources:
  - files:
      - design/rsPkg.sv
      - design/slotPicker.sv
      - design/rsEntryTable.sv
      - design/issueStage.sv
      - design/completeStage.sv
      - design/reservationStation.sv
  - target: test
    files:
      - verification/reservationStation_properties.sv
      - verification/reservationStationTb.sv
